/* design/pat_settings.svh */
`ifndef PAT_SETTINGS_SVH
`define PAT_SETTINGS_SVH

// ========================================
// datapath widths
// ========================================
`define PAT_DATA_WIDTH     8
`define PAT_INSTR_WIDTH    23
`define PAT_PC_WIDTH       10
`define PAT_NUM_REGS       8
`define PAT_REG_ADR_WIDTH  3
`define PAT_FIELDP_WIDTH   5
`define PAT_BUFP_WIDTH     3

// ========================================
// pipeline timing
// ========================================
`define PAT_FIELD_LATENCY  4 // field read pointer to write pointer
`define PAT_NUM_BUBBLES    4 // slots squashed after a jump or reset
`define PAT_CALL_ADJUST    4 // pc runs this far ahead of the call

// always condition, i3 prefix, i0 prefix, nop opcode
`define PAT_INSTR_NOP      23'h006ff5

`endif

/* design/pat_isa_pkg.sv */
package pat_isa_pkg;
`include "pat_settings.svh"

	// i8 opcode space, 4'hf escapes to i3
	typedef enum logic [3:0] {
		OP8_ORI   = 4'h0,
		OP8_ORR   = 4'h1,
		OP8_ANDI  = 4'h2,
		OP8_ANDR  = 4'h3,
		OP8_ADDI  = 4'h4,
		OP8_ADDR  = 4'h5,
		OP8_SUBI  = 4'h6,
		OP8_SUBR  = 4'h7,
		OP8_LDI   = 4'h8,
		OP8_SETSP = 4'hc, // decoded as nop
		OP8_BF    = 4'hd,
		OP8_CALL  = 4'he,
		OP8_I3    = 4'hf
	} op8_e;

	// i3 opcode space, 4'hf escapes to i0
	typedef enum logic [3:0] {
		OP3_SHLZI = 4'h0,
		OP3_SHLZR = 4'h1,
		OP3_SHLOI = 4'h2,
		OP3_SHLOR = 4'h3,
		OP3_SHRZI = 4'h4,
		OP3_SHRZR = 4'h5,
		OP3_SHROI = 4'h6,
		OP3_SHROR = 4'h7,
		OP3_IN    = 4'h8,
		OP3_OUT   = 4'hb,
		OP3_SETB  = 4'hc,
		OP3_I0    = 4'hf
	} op3_e;

	typedef enum logic [3:0] {
		OP0_NOT  = 4'h0,
		OP0_TEST = 4'h2,
		OP0_RET  = 4'h3,
		OP0_NOP  = 4'h5
	} op0_e;

	typedef enum logic [1:0] {
		COND_Z  = 2'd0,
		COND_NZ = 2'd1,
		COND_N  = 2'd2,
		COND_AL = 2'd3
	} cond_e;

	// i3 opcode in imm[7:4], i3 immediate in imm[2:0], i0 opcode in imm[3:0]
	typedef struct packed {
		logic [`PAT_REG_ADR_WIDTH-1:0] rn;
		logic [`PAT_FIELDP_WIDTH-1:0]  fieldp;
		cond_e                         cond;
		logic                          field_op;
		op8_e                          op8;
		logic [7:0]                    imm;
	} instr_t;

endpackage

/* design/pat_pipe_pkg.sv */
package pat_pipe_pkg;
`include "pat_settings.svh"

	typedef enum logic [3:0] {
		ALU_OR,
		ALU_AND,
		ALU_NOT,
		ALU_ADD,
		ALU_SUB,
		ALU_SHLZ,
		ALU_SHLO,
		ALU_SHRZ,
		ALU_SHRO,
		ALU_PASS
	} alu_op_e;

	// ========================================
	// decode to commit
	// ========================================
	typedef struct packed {
		alu_op_e                       alu_op;
		logic [`PAT_DATA_WIDTH-1:0]    a;
		logic [`PAT_DATA_WIDTH-1:0]    b;
		logic [`PAT_REG_ADR_WIDTH-1:0] rd;
		pat_isa_pkg::cond_e            cond;
		logic                          wr_reg;
		logic                          wr_field;
		logic                          wr_out;
		logic                          set_buf;
		logic                          test;
		logic                          branch;
		logic                          call;
		logic                          ret;
		logic [7:0]                    imm;
	} decoded_t;

	// reg write and set buffer act at the commit edge, the rest one edge later
	typedef struct packed {
		logic                          reg_we;
		logic [`PAT_REG_ADR_WIDTH-1:0] reg_adr;
		logic [`PAT_DATA_WIDTH-1:0]    reg_data;
		logic                          field_we;
		logic [`PAT_DATA_WIDTH-1:0]    field_data;
		logic                          set_buf;
		logic [`PAT_BUFP_WIDTH:0]      buf_code; // {high side, pointer}
		logic                          jump;
		logic                          call;
		logic                          ret;
		logic [`PAT_DATA_WIDTH-1:0]    offset;
	} commit_t;

	typedef struct packed {
		logic [`PAT_DATA_WIDTH-1:0] in2;
		logic [`PAT_DATA_WIDTH-1:0] in1;
		logic [`PAT_DATA_WIDTH-1:0] in0;
	} in_ports_t;

	typedef struct packed {
		logic                         en_low;
		logic                         en_high;
		logic [`PAT_DATA_WIDTH-1:0]   data;
		logic [`PAT_FIELDP_WIDTH-1:0] wp;
	} field_bus_t;

endpackage

/* design/decode_stage.sv */
`timescale 1ns/1ps
`include "pat_settings.svh"

module decode_stage (
	input  logic                          clk,
	input  logic                          reset,
	input  pat_isa_pkg::instr_t           i_instruction,
	input  pat_pipe_pkg::in_ports_t       i_in,
	input  logic [`PAT_DATA_WIDTH-1:0]    i_reg_data,
	input  logic [`PAT_DATA_WIDTH-1:0]    i_field_value,
	output logic [`PAT_REG_ADR_WIDTH-1:0] o_reg_adr,
	output logic [`PAT_FIELDP_WIDTH-1:0]  o_fieldp,
	output pat_pipe_pkg::decoded_t        o_decoded
);
	import pat_isa_pkg::*;
	import pat_pipe_pkg::*;

	localparam int W = `PAT_DATA_WIDTH;

	instr_t instr_q;
	op3_e op3;
	op0_e op0;
	alu_op_e alu_op;
	logic is_i8, is_i3, is_i0;
	logic op_ldi, op_in, op_out, op_setb, op_test, op_ret, op_bf, op_call, op_not;
	logic result_op;
	logic b_is_imm;
	logic [W-1:0] imm_all;
	logic [W-1:0] in_value;
	logic [W-1:0] opa;

	always_ff @(posedge clk)
	begin
		if (reset)
			instr_q <= `PAT_INSTR_NOP;
		else
			instr_q <= i_instruction;
	end

	assign o_fieldp  = i_instruction.fieldp; // registered in field_port at the same edge
	assign o_reg_adr = instr_q.rn;

	// ========================================
	// classify by prefix
	// ========================================
	assign op3   = op3_e'(instr_q.imm[7:4]);
	assign op0   = op0_e'(instr_q.imm[3:0]);
	assign is_i8 = (instr_q.op8 != OP8_I3);
	assign is_i3 = !is_i8 && (op3 != OP3_I0);
	assign is_i0 = !is_i8 && !is_i3;

	assign op_ldi  = is_i8 && (instr_q.op8 == OP8_LDI);
	assign op_bf   = is_i8 && (instr_q.op8 == OP8_BF);
	assign op_call = is_i8 && (instr_q.op8 == OP8_CALL);
	assign op_in   = is_i3 && (op3 == OP3_IN);
	assign op_out  = is_i3 && (op3 == OP3_OUT);
	assign op_setb = is_i3 && (op3 == OP3_SETB);
	assign op_not  = is_i0 && (op0 == OP0_NOT);
	assign op_test = is_i0 && (op0 == OP0_TEST);
	assign op_ret  = is_i0 && (op0 == OP0_RET);

	// ori..ldi, the shifts, in and not leave a result in reg or field
	assign result_op = (is_i8 && (instr_q.op8 <= OP8_LDI)) || (is_i3 && (op3 <= OP3_IN)) || op_not;

	assign imm_all  = is_i8 ? instr_q.imm : {{(W-3){1'b0}}, instr_q.imm[2:0]};
	assign b_is_imm = is_i8 ? !instr_q.op8[0] : !op3[0];

	always_comb
	begin
		alu_op = ALU_PASS;
		if (is_i8)
		begin
			case (instr_q.op8)
				OP8_ORI, OP8_ORR, OP8_LDI: alu_op = ALU_OR; // ldi ors into a zero a
				OP8_ANDI, OP8_ANDR:        alu_op = ALU_AND;
				OP8_ADDI, OP8_ADDR:        alu_op = ALU_ADD;
				OP8_SUBI, OP8_SUBR:        alu_op = ALU_SUB;
				default:                   alu_op = ALU_PASS;
			endcase
		end
		else if (is_i3)
		begin
			case (op3)
				OP3_SHLZI, OP3_SHLZR: alu_op = ALU_SHLZ;
				OP3_SHLOI, OP3_SHLOR: alu_op = ALU_SHLO;
				OP3_SHRZI, OP3_SHRZR: alu_op = ALU_SHRZ;
				OP3_SHROI, OP3_SHROR: alu_op = ALU_SHRO;
				default:              alu_op = ALU_PASS;
			endcase
		end
		else if (op_not)
			alu_op = ALU_NOT;
	end

	always_comb
	begin
		case (instr_q.imm[2:0])
			3'b010:  in_value = i_in.in1;
			3'b100:  in_value = i_in.in2;
			default: in_value = i_in.in0; // 001 or not one-hot
		endcase
	end

	// ldi wins over field op
	always_comb
	begin
		if (op_ldi)
			opa = '0;
		else if (instr_q.field_op)
			opa = i_field_value;
		else if (op_in)
			opa = in_value;
		else
			opa = i_reg_data;
	end

	// ========================================
	// second pipeline register
	// ========================================
	always_ff @(posedge clk)
	begin
		o_decoded.alu_op   <= alu_op;
		o_decoded.a        <= opa;
		o_decoded.b        <= b_is_imm ? imm_all : i_reg_data;
		o_decoded.rd       <= instr_q.rn;
		o_decoded.cond     <= instr_q.cond;
		o_decoded.wr_reg   <= result_op && !instr_q.field_op;
		o_decoded.wr_field <= result_op && instr_q.field_op;
		o_decoded.wr_out   <= op_out;
		o_decoded.set_buf  <= op_setb;
		o_decoded.test     <= op_test;
		o_decoded.branch   <= op_bf;
		o_decoded.call     <= op_call;
		o_decoded.ret      <= op_ret;
		o_decoded.imm      <= instr_q.imm;
	end

endmodule

/* design/register_file.sv */
`timescale 1ns/1ps
`include "pat_settings.svh"

module register_file (
	input  logic                          clk,
	input  logic [`PAT_REG_ADR_WIDTH-1:0] i_read_adr,
	input  pat_pipe_pkg::commit_t         i_commit,
	output logic [`PAT_DATA_WIDTH-1:0]    o_read_data
);

	logic [`PAT_DATA_WIDTH-1:0] regs [`PAT_NUM_REGS];

	assign o_read_data = regs[i_read_adr]; // async read

	// written at the commit edge
	always_ff @(posedge clk)
	begin
		if (i_commit.reg_we)
			regs[i_commit.reg_adr] <= i_commit.reg_data;
	end

endmodule

/* design/alu.sv */
`timescale 1ns/1ps
`include "pat_settings.svh"

module alu (
	input  pat_pipe_pkg::decoded_t     i_decoded,
	output logic [`PAT_DATA_WIDTH-1:0] o_result
);
	import pat_pipe_pkg::*;

	localparam int W = `PAT_DATA_WIDTH;
	localparam logic [W-1:0] ONES = '1;

	logic [2:0] amt;
	logic [W-1:0] a;
	logic [W-1:0] b;

	assign a   = i_decoded.a;
	assign b   = i_decoded.b;
	assign amt = {1'b0, b[1:0]} + 3'd1; // 1 to 4 places

	// ========================================
	// result select
	// ========================================
	always_comb
	begin
		case (i_decoded.alu_op)
			ALU_OR:   o_result = a | b;
			ALU_AND:  o_result = a & b;
			ALU_NOT:  o_result = ~a;
			ALU_ADD:  o_result = a + b; // wraps at 256
			ALU_SUB:  o_result = a - b;
			ALU_SHLZ: o_result = a << amt;
			ALU_SHLO: o_result = (a << amt) | ~(ONES << amt); // ones into the bottom
			ALU_SHRZ: o_result = a >> amt;
			ALU_SHRO: o_result = (a >> amt) | ~(ONES >> amt); // ones from the top
			default:  o_result = a;
		endcase
	end

endmodule

/* design/commit_control.sv */
`timescale 1ns/1ps
`include "pat_settings.svh"

module commit_control (
	input  logic                       clk,
	input  logic                       reset,
	input  pat_pipe_pkg::decoded_t     i_decoded,
	input  logic [`PAT_DATA_WIDTH-1:0] i_result,
	output pat_pipe_pkg::commit_t      o_commit,
	output logic [`PAT_DATA_WIDTH-1:0] o_out
);
	import pat_isa_pkg::*;

	localparam int W     = `PAT_DATA_WIDTH;
	localparam int CNT_W = $clog2(`PAT_NUM_BUBBLES + 1);

	logic flag_z, flag_n;
	logic [CNT_W-1:0] squash_cnt;
	logic [1:0] kill_q; // [0] slot just sampled, [1] slot now in commit
	logic cond_ok, exec, take_jump;
	logic field_we_q, jump_q, call_q, ret_q;
	logic [W-1:0] field_data_q;
	logic [W-1:0] offset_q;

	always_comb
	begin
		case (i_decoded.cond)
			COND_Z:  cond_ok = flag_z;
			COND_NZ: cond_ok = !flag_z;
			COND_N:  cond_ok = flag_n;
			default: cond_ok = 1'b1;
		endcase
	end

	assign exec      = !kill_q[1] && cond_ok;
	assign take_jump = exec && (i_decoded.branch || i_decoded.call || i_decoded.ret);

	// ========================================
	// flags, squash window, delayed strobes
	// ========================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			squash_cnt <= CNT_W'(`PAT_NUM_BUBBLES);
			kill_q     <= 2'b11;
			flag_z     <= 1'b1;
			flag_n     <= 1'b0;
			field_we_q <= 1'b0;
			jump_q     <= 1'b0;
			call_q     <= 1'b0;
			ret_q      <= 1'b0;
		end
		else
		begin
			if (take_jump)
			begin
				squash_cnt <= CNT_W'(`PAT_NUM_BUBBLES);
				kill_q     <= 2'b11; // slots already behind the jump die too
			end
			else
			begin
				if (squash_cnt != '0)
					squash_cnt <= squash_cnt - 1'b1;
				kill_q <= {kill_q[0], squash_cnt != '0};
			end
			if (exec && i_decoded.test)
			begin
				flag_z <= (i_decoded.a == '0);
				flag_n <= i_decoded.a[W-1];
			end
			field_we_q <= exec && i_decoded.wr_field;
			jump_q     <= take_jump;
			call_q     <= exec && i_decoded.call;
			ret_q      <= exec && i_decoded.ret;
		end
	end

	always_ff @(posedge clk)
	begin
		field_data_q <= i_result;
		offset_q     <= i_decoded.imm;
		if (exec && i_decoded.wr_out)
			o_out <= i_decoded.a;
	end

	always_comb
	begin
		o_commit.reg_we     = exec && i_decoded.wr_reg;
		o_commit.reg_adr    = i_decoded.rd;
		o_commit.reg_data   = i_result;
		o_commit.field_we   = field_we_q;
		o_commit.field_data = field_data_q;
		o_commit.set_buf    = exec && i_decoded.set_buf;
		o_commit.buf_code   = i_decoded.imm[`PAT_BUFP_WIDTH:0];
		o_commit.jump       = jump_q;
		o_commit.call       = call_q;
		o_commit.ret        = ret_q;
		o_commit.offset     = offset_q;
	end

endmodule

/* design/field_port.sv */
`timescale 1ns/1ps
`include "pat_settings.svh"

module field_port (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [`PAT_FIELDP_WIDTH-1:0] i_fieldp,
	input  pat_pipe_pkg::commit_t        i_commit,
	input  logic [`PAT_DATA_WIDTH-1:0]   i_field_low,
	input  logic [`PAT_DATA_WIDTH-1:0]   i_field_high,
	output logic [`PAT_BUFP_WIDTH-1:0]   o_bufp,
	output logic [`PAT_FIELDP_WIDTH-1:0] o_fieldp,
	output logic [`PAT_DATA_WIDTH-1:0]   o_field_value,
	output pat_pipe_pkg::field_bus_t     o_field
);

	localparam int LAT = `PAT_FIELD_LATENCY;

	logic high_sel; // 0 selects the low side
	logic en_low_q, en_high_q;
	logic [`PAT_DATA_WIDTH-1:0] data_q;
	logic [`PAT_FIELDP_WIDTH-1:0] fieldp_hist [LAT];

	assign o_field_value = high_sel ? i_field_high : i_field_low;

	// ========================================
	// buffer select and pointers
	// ========================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_bufp   <= '0;
			high_sel <= 1'b0;
			o_fieldp <= '0;
			for (int i = 0; i < LAT; i++)
				fieldp_hist[i] <= '0;
		end
		else
		begin
			o_fieldp       <= i_fieldp;
			fieldp_hist[0] <= o_fieldp;
			for (int i = 1; i < LAT; i++)
				fieldp_hist[i] <= fieldp_hist[i-1];
			if (i_commit.set_buf)
			begin
				o_bufp   <= i_commit.buf_code[`PAT_BUFP_WIDTH-1:0];
				high_sel <= i_commit.buf_code[`PAT_BUFP_WIDTH];
			end
		end
	end

	// write side follows the select in force at this edge
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			en_low_q  <= 1'b0;
			en_high_q <= 1'b0;
			data_q    <= '0;
		end
		else
		begin
			en_low_q  <= i_commit.field_we && !high_sel;
			en_high_q <= i_commit.field_we && high_sel;
			if (i_commit.field_we)
				data_q <= i_commit.field_data;
		end
	end

	always_comb
	begin
		o_field.en_low  = en_low_q;
		o_field.en_high = en_high_q;
		o_field.data    = data_q;
		o_field.wp      = fieldp_hist[LAT-1]; // trails o_fieldp by LAT edges
	end

endmodule

/* design/program_counter.sv */
`timescale 1ns/1ps
`include "pat_settings.svh"

module program_counter (
	input  logic                     clk,
	input  logic                     reset,
	input  pat_pipe_pkg::commit_t    i_commit,
	output logic [`PAT_PC_WIDTH-1:0] o_pc
);

	localparam int PW = `PAT_PC_WIDTH;
	localparam int W  = `PAT_DATA_WIDTH;

	logic [PW-1:0] pc_q;
	logic [PW-1:0] lr_q;
	logic [PW-1:0] target;

	assign target = pc_q + {{(PW-W){i_commit.offset[W-1]}}, i_commit.offset}; // signed offset
	assign o_pc   = pc_q;

	always_ff @(posedge clk)
	begin
		if (reset)
			pc_q <= '0;
		else if (i_commit.jump && i_commit.ret)
			pc_q <= lr_q;
		else if (i_commit.jump)
			pc_q <= target;
		else
			pc_q <= pc_q + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (i_commit.call)
			lr_q <= pc_q - PW'(`PAT_CALL_ADJUST); // pc is already past the call
	end

endmodule

/* design/pat_top.sv */
`timescale 1ns/1ps
`include "pat_settings.svh"

module pat_top (
	input  logic                         clk,
	input  logic                         reset,
	input  pat_isa_pkg::instr_t          i_instruction,
	input  pat_pipe_pkg::in_ports_t      i_in,
	input  logic [`PAT_DATA_WIDTH-1:0]   i_field_low,
	input  logic [`PAT_DATA_WIDTH-1:0]   i_field_high,
	output logic [`PAT_PC_WIDTH-1:0]     o_pc,
	output logic                         o_jump,
	output logic [`PAT_BUFP_WIDTH-1:0]   o_bufp,
	output logic [`PAT_FIELDP_WIDTH-1:0] o_fieldp,
	output pat_pipe_pkg::field_bus_t     o_field,
	output logic [`PAT_DATA_WIDTH-1:0]   o_out
);
	import pat_pipe_pkg::*;

	logic [`PAT_REG_ADR_WIDTH-1:0] reg_adr;
	logic [`PAT_DATA_WIDTH-1:0] reg_data;
	logic [`PAT_DATA_WIDTH-1:0] field_value;
	logic [`PAT_DATA_WIDTH-1:0] result;
	logic [`PAT_FIELDP_WIDTH-1:0] dec_fieldp;
	decoded_t decoded;
	commit_t commit;

	assign o_jump = commit.jump;

	// ========================================
	// stage 1
	// ========================================
	decode_stage u_decode (
		.clk(clk), .reset(reset), .i_instruction(i_instruction), .i_in(i_in),
		.i_reg_data(reg_data), .i_field_value(field_value),
		.o_reg_adr(reg_adr), .o_fieldp(dec_fieldp), .o_decoded(decoded)
	);

	register_file u_regs (
		.clk(clk), .i_read_adr(reg_adr), .i_commit(commit), .o_read_data(reg_data)
	);

	// stage 2
	alu u_alu (.i_decoded(decoded), .o_result(result));

	commit_control u_commit (
		.clk(clk), .reset(reset), .i_decoded(decoded), .i_result(result),
		.o_commit(commit), .o_out(o_out)
	);

	field_port u_field (
		.clk(clk), .reset(reset), .i_fieldp(dec_fieldp), .i_commit(commit),
		.i_field_low(i_field_low), .i_field_high(i_field_high), .o_bufp(o_bufp),
		.o_fieldp(o_fieldp), .o_field_value(field_value), .o_field(o_field)
	);

	program_counter u_pc (.clk(clk), .reset(reset), .i_commit(commit), .o_pc(o_pc));

endmodule

/* verification/pat_tb.sv */
`timescale 1ns/1ps
`include "pat_settings.svh"

module pat_tb;
	import pat_isa_pkg::*;
	import pat_pipe_pkg::*;

	localparam int W = `PAT_DATA_WIDTH;
	localparam int PW = `PAT_PC_WIDTH;
	localparam int N_ALU = 40;
	localparam int N_SHIFT = 6;
	localparam int EST_ISSUES = 4 + N_ALU * 3 + N_SHIFT * 8 * 3 + 30 + 8 + 12 + 16;
	localparam int MAX_SLOTS = 7 * EST_ISSUES + 40; // every issue fits in 7 slots

	logic clk;
	logic reset;
	instr_t instruction;
	in_ports_t in_ports;
	logic [W-1:0] field_low;
	logic [W-1:0] field_high;
	logic [PW-1:0] pc;
	logic jump;
	logic [`PAT_BUFP_WIDTH-1:0] bufp;
	logic [`PAT_FIELDP_WIDTH-1:0] fieldp;
	field_bus_t field_bus;
	logic [W-1:0] out_val;

	// ========================================
	// reference model state
	// ========================================
	logic [W-1:0] model_regs [`PAT_NUM_REGS];
	logic flag_z;
	logic flag_n;
	logic high_sel;
	in_ports_t drv_in;
	logic [W-1:0] drv_low;
	logic [W-1:0] drv_high;
	int slot;
	int fail_count;
	logic [W-1:0] out_at [int];
	logic [`PAT_BUFP_WIDTH-1:0] bufp_at [int];
	logic [1:0] fen_at [int]; // {high, low}
	logic [W-1:0] fdata_at [int];
	int jump_at [int]; // 1 branch, 2 call, 3 return
	logic [W-1:0] off_at [int];
	logic [`PAT_FIELDP_WIDTH-1:0] fp_sent [int];
	logic [W-1:0] cur_out;
	logic out_known;
	logic [`PAT_BUFP_WIDTH-1:0] cur_bufp;
	logic [PW-1:0] prev_pc;
	logic [PW-1:0] jump_pc;
	logic [PW-1:0] link;
	logic [W-1:0] jump_off;
	int prev_jump;

	pat_top uut (
		.clk(clk), .reset(reset), .i_instruction(instruction), .i_in(in_ports),
		.i_field_low(field_low), .i_field_high(field_high), .o_pc(pc), .o_jump(jump),
		.o_bufp(bufp), .o_fieldp(fieldp), .o_field(field_bus), .o_out(out_val)
	);

	always #20 clk = ~clk;

	task automatic stop_with_fail(input string msg);
		fail_count++;
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "stopped on first failure");
	endtask

	task automatic report_value(input string name, input int got, input int exp);
		stop_with_fail($sformatf("ERROR @%0t: %s is %0h, expected %0h", $time, name, got, exp));
	endtask

	function automatic logic [W-1:0] rand8();
		logic [31:0] r;
		r = $urandom;
		return r[W-1:0];
	endfunction

	function automatic instr_t mk(input logic [2:0] rn, input cond_e c, input logic fop,
			input op8_e op, input logic [7:0] imm);
		instr_t t;
		logic [31:0] r;
		r = $urandom;
		t.rn = rn;
		t.fieldp = r[`PAT_FIELDP_WIDTH-1:0];
		t.cond = c;
		t.field_op = fop;
		t.op8 = op;
		t.imm = imm;
		return t;
	endfunction

	function automatic instr_t mk3(input logic [2:0] rn, input logic fop, input op3_e op,
			input logic [3:0] low);
		return mk(rn, COND_AL, fop, OP8_I3, {op, low});
	endfunction

	function automatic instr_t mk0(input logic [2:0] rn, input op0_e op);
		return mk(rn, COND_AL, 1'b0, OP8_I3, {4'hf, op});
	endfunction

	function automatic logic cond_holds(input cond_e c);
		case (c)
			COND_Z:  return flag_z;
			COND_NZ: return !flag_z;
			COND_N:  return flag_n;
			default: return 1'b1;
		endcase
	endfunction

	// shift by code+1 places one at a time
	function automatic logic [W-1:0] shift_rule(input logic [W-1:0] a, input logic [1:0] code,
			input logic left, input logic fill);
		logic [W-1:0] v;
		v = a;
		for (int i = 0; i <= int'(code); i++)
			v = left ? {v[W-2:0], fill} : {fill, v[W-1:1]};
		return v;
	endfunction

	// ========================================
	// per slot checks at the falling edge
	// ========================================
	task automatic check_slot();
		logic [1:0] fen;
		logic [PW-1:0] exp_pc;
		fen = fen_at.exists(slot) ? fen_at[slot] : 2'b00;
		if (out_at.exists(slot))
		begin
			cur_out = out_at[slot];
			out_known = 1'b1;
		end
		if (bufp_at.exists(slot))
			cur_bufp = bufp_at[slot];
		if (out_known)
		begin
			assert (out_val == cur_out) else report_value("o_out", out_val, cur_out);
		end
		assert (bufp == cur_bufp) else report_value("o_bufp", bufp, cur_bufp);
		if (prev_jump == 3)
			exp_pc = link;
		else if (prev_jump != 0)
			exp_pc = jump_pc + {{(PW-W){jump_off[W-1]}}, jump_off};
		else
			exp_pc = prev_pc + PW'(1);
		assert (pc == exp_pc) else report_value("o_pc", pc, exp_pc);
		assert (jump == jump_at.exists(slot)) else report_value("o_jump", jump, !jump);
		prev_jump = jump_at.exists(slot) ? jump_at[slot] : 0;
		if (prev_jump != 0)
		begin
			jump_pc = pc;
			jump_off = off_at[slot];
			if (prev_jump == 2)
				link = pc - PW'(`PAT_CALL_ADJUST);
		end
		prev_pc = pc;
		assert ({field_bus.en_high, field_bus.en_low} == fen)
			else report_value("field enables", {field_bus.en_high, field_bus.en_low}, fen);
		if (fen != 2'b00)
		begin
			assert (field_bus.data == fdata_at[slot])
				else report_value("field data", field_bus.data, fdata_at[slot]);
		end
		assert (fieldp == fp_sent[slot-1]) else report_value("o_fieldp", fieldp, fp_sent[slot-1]);
		if (slot > `PAT_FIELD_LATENCY)
		begin
			assert (field_bus.wp == fp_sent[slot-1-`PAT_FIELD_LATENCY])
				else report_value("o_fieldwp", field_bus.wp,
					fp_sent[slot-1-`PAT_FIELD_LATENCY]);
		end
	endtask

	task automatic send(input instr_t ins);
		@(posedge clk);
		instruction <= ins;
		in_ports <= drv_in;
		field_low <= drv_low;
		field_high <= drv_high;
		slot++;
		fp_sent[slot] = ins.fieldp;
		@(negedge clk);
		check_slot();
	endtask

	// models one instruction and sends it with its trailing nops
	task automatic issue(input instr_t ins);
		logic [3:0] op3;
		logic [3:0] op0;
		logic i3;
		logic i0;
		logic [W-1:0] a;
		logic [W-1:0] b;
		logic [W-1:0] res;
		logic has_res;
		logic exec;
		int kind;
		int d;
		op3 = ins.imm[7:4];
		op0 = ins.imm[3:0];
		i3 = (ins.op8 == OP8_I3) && (op3 != 4'hf);
		i0 = (ins.op8 == OP8_I3) && (op3 == 4'hf);
		d = slot + 1; // slot the instruction is driven in
		has_res = 1'b0;
		kind = 0;
		res = '0;
		a = ins.field_op ? (high_sel ? drv_high : drv_low) : model_regs[ins.rn];
		exec = cond_holds(ins.cond);
		if (!i3 && !i0)
		begin
			b = ins.op8[0] ? model_regs[ins.rn] : ins.imm;
			has_res = 1'b1;
			case (ins.op8)
				OP8_ORI, OP8_ORR:   res = a | b;
				OP8_ANDI, OP8_ANDR: res = a & b;
				OP8_ADDI, OP8_ADDR: res = a + b;
				OP8_SUBI, OP8_SUBR: res = a - b;
				OP8_LDI:            res = ins.imm;
				default:            has_res = 1'b0;
			endcase
			if (ins.op8 == OP8_BF)
				kind = 1;
			if (ins.op8 == OP8_CALL)
				kind = 2;
		end
		else if (i3)
		begin
			b = op3[0] ? model_regs[ins.rn] : {{(W-3){1'b0}}, ins.imm[2:0]};
			if (op3 < 4'h8)
			begin
				has_res = 1'b1;
				res = shift_rule(a, b[1:0], !op3[2], op3[1]);
			end
			else if (op3 == OP3_IN)
			begin
				has_res = 1'b1;
				if (ins.field_op)
					res = a;
				else if (ins.imm[2:0] == 3'b010)
					res = drv_in.in1;
				else if (ins.imm[2:0] == 3'b100)
					res = drv_in.in2;
				else
					res = drv_in.in0;
			end
		end
		else if (op0 == OP0_NOT)
		begin
			has_res = 1'b1;
			res = ~a;
		end
		else if (op0 == OP0_RET)
			kind = 3;
		if (exec)
		begin
			if (has_res && ins.field_op)
			begin
				fen_at[d+4] = high_sel ? 2'b10 : 2'b01;
				fdata_at[d+4] = res;
			end
			else if (has_res)
				model_regs[ins.rn] = res;
			if (i3 && op3 == OP3_OUT)
				out_at[d+3] = a;
			if (i3 && op3 == OP3_SETB)
			begin
				high_sel = ins.imm[3];
				bufp_at[d+3] = ins.imm[2:0];
			end
			if (i0 && op0 == OP0_TEST)
			begin
				flag_z = (a == '0);
				flag_n = a[W-1];
			end
			if (kind != 0)
			begin
				jump_at[d+3] = kind;
				off_at[d+3] = ins.imm;
			end
		end
		send(ins);
		repeat (2) send(instr_t'(`PAT_INSTR_NOP));
		if (exec && kind != 0)
			repeat (`PAT_NUM_BUBBLES) send(instr_t'(`PAT_INSTR_NOP));
	endtask

	// out in the shadow of a branch must not commit
	task automatic branch_with_squashed_out(input logic [2:0] rn);
		instr_t br;
		int d;
		br = mk(3'd0, COND_AL, 1'b0, OP8_BF, rand8());
		d = slot + 1;
		jump_at[d+3] = 1;
		off_at[d+3] = br.imm;
		send(br);
		repeat (2) send(instr_t'(`PAT_INSTR_NOP));
		send(mk3(rn, 1'b0, OP3_OUT, 4'h0));
		repeat (`PAT_NUM_BUBBLES - 1) send(instr_t'(`PAT_INSTR_NOP));
	endtask

	initial
	begin
		#(MAX_SLOTS * 40 + 400);
		stop_with_fail("timeout: the run did not finish in the expected time");
	end

	initial
	begin
		logic [2:0] r;
		logic [2:0] r2;
		logic [W-1:0] cond_vals [3];
		op8_e alu_ops [8];
		void'($urandom(76398));
		clk = 1'b0;
		reset = 1'b1;
		instruction = instr_t'(`PAT_INSTR_NOP);
		in_ports = '0;
		field_low = '0;
		field_high = '0;
		drv_in = '0;
		drv_low = '0;
		drv_high = '0;
		foreach (model_regs[i])
			model_regs[i] = '0;
		flag_z = 1'b1;
		flag_n = 1'b0;
		high_sel = 1'b0;
		slot = 0;
		fail_count = 0;
		fp_sent[0] = instruction.fieldp;
		out_known = 1'b0;
		cur_bufp = '0;
		prev_pc = '0;
		prev_jump = 0;
		alu_ops = '{OP8_ORI, OP8_ORR, OP8_ANDI, OP8_ANDR,
			OP8_ADDI, OP8_ADDR, OP8_SUBI, OP8_SUBR};
		cond_vals = '{8'h00, 8'h85, 8'h21}; // zero, negative, positive
		repeat (2) @(posedge clk);
		@(negedge clk);
		assert (pc == '0 && !jump && !field_bus.en_low && !field_bus.en_high
				&& field_bus.data == '0)
			else stop_with_fail("outputs are not at their reset values during reset");
		@(posedge clk);
		reset <= 1'b0;
		repeat (`PAT_NUM_BUBBLES) send(instr_t'(`PAT_INSTR_NOP));

		// ========================================
		// arithmetic, logic and shifts
		// ========================================
		for (int i = 0; i < N_ALU; i++)
		begin
			r = 3'(rand8());
			issue(mk(r, COND_AL, 1'b0, OP8_LDI, rand8()));
			if (i % 9 == 8)
				issue(mk0(r, OP0_NOT));
			else
				issue(mk(r, COND_AL, 1'b0, alu_ops[i % 9], rand8()));
			issue(mk3(r, 1'b0, OP3_OUT, 4'h0));
		end
		for (int k = 0; k < 8; k++)
		begin
			for (int i = 0; i < N_SHIFT; i++)
			begin
				r = 3'(rand8());
				issue(mk(r, COND_AL, 1'b0, OP8_LDI, rand8()));
				issue(mk3(r, 1'b0, op3_e'(k), {1'b0, 3'(rand8())}));
				issue(mk3(r, 1'b0, OP3_OUT, 4'h0));
			end
		end

		// conditions against flags set by test
		foreach (cond_vals[v])
		begin
			issue(mk(3'd1, COND_AL, 1'b0, OP8_LDI, cond_vals[v]));
			issue(mk0(3'd1, OP0_TEST));
			for (int c = 0; c < 4; c++)
			begin
				issue(mk(3'd2, COND_AL, 1'b0, OP8_LDI, rand8()));
				issue(mk(3'd2, cond_e'(c), 1'b0, OP8_I3, {OP3_OUT, 4'h0}));
			end
		end

		// ========================================
		// input ports and field buffer
		// ========================================
		foreach (cond_vals[v])
		begin
			drv_in = {rand8(), rand8(), rand8()};
			issue(mk3(3'd3, 1'b0, OP3_IN, {1'b0, 3'b001 << v}));
			issue(mk3(3'd3, 1'b0, OP3_OUT, 4'h0));
		end
		drv_in = {rand8(), rand8(), rand8()};
		issue(mk3(3'd4, 1'b0, OP3_IN, 4'h0)); // not one-hot reads port 0
		issue(mk3(3'd4, 1'b0, OP3_OUT, 4'h0));
		for (int i = 0; i < 4; i++)
		begin
			issue(mk3(3'd0, 1'b0, OP3_SETB, {i[0], 3'(rand8())}));
			drv_low = rand8();
			drv_high = rand8();
			issue(mk3(3'd0, 1'b1, OP3_OUT, 4'h0));
			issue(mk(3'd5, COND_AL, 1'b1, OP8_ADDI, rand8()));
		end

		// ========================================
		// branch, call and return
		// ========================================
		issue(mk(3'd6, COND_AL, 1'b0, OP8_LDI, cur_out ^ 8'h5a));
		branch_with_squashed_out(3'd6);
		issue(mk(3'd0, COND_AL, 1'b0, OP8_BF, rand8()));
		for (int i = 0; i < 2; i++)
		begin
			issue(mk(3'd0, COND_AL, 1'b0, OP8_CALL, rand8()));
			r2 = 3'(rand8());
			issue(mk(r2, COND_AL, 1'b0, OP8_LDI, rand8()));
			issue(mk3(r2, 1'b0, OP3_OUT, 4'h0));
			issue(mk0(3'd0, OP0_RET));
		end
		repeat (6) send(instr_t'(`PAT_INSTR_NOP));

		if (fail_count == 0)
		begin
			$display(">>> PASS");
			$finish;
		end
		else
			stop_with_fail("checks failed during the run");
	end

endmodule

/* pat_top.f */
+incdir+design
design/pat_isa_pkg.sv
design/pat_pipe_pkg.sv
design/decode_stage.sv
design/register_file.sv
design/alu.sv
design/commit_control.sv
design/field_port.sv
design/program_counter.sv
design/pat_top.sv
verification/pat_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := pat_tb
FILELIST  := pat_top.f
FLAGS     := --timing --assert -Wno-fatal
BUILD_DIR := obj_dir
PASS_MSG  := >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
